/* rtl/pkt_bus_pkg.sv */
package pkt_bus_pkg;

   // ------------------------------------------------------------
   // packet bus
   // ------------------------------------------------------------
   typedef logic [31:0] word_t;
   typedef logic [3:0]  ctrl_t;

   localparam ctrl_t ctrl_payload    = 4'd0;
   localparam ctrl_t ctrl_module_hdr = 4'd2;   // carries source port.

   typedef struct packed {
      word_t data;
      ctrl_t ctrl;
   } pkt_word_t;

   typedef logic [2:0] port_t;
   typedef logic [7:0] port_mask_t;             // one bit per output port.

   typedef struct packed {
      port_mask_t dst_ports;
      port_t      src_port;
   } fwd_decision_t;

   // ------------------------------------------------------------
   // register bus and table
   // ------------------------------------------------------------
   typedef logic [7:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;

   typedef struct packed {
      logic        valid;
      port_t       port;
      logic [47:0] mac;
   } table_entry_t;

endpackage

/* rtl/eth_pkg.sv */
package eth_pkg;
   import pkt_bus_pkg::*;

   typedef logic [47:0] mac_t;
   typedef logic [15:0] ethertype_t;

   localparam mac_t broadcast_mac = 48'hffff_ffff_ffff;

   // header fields as seen by the lookup.
   typedef struct packed {
      mac_t       dst_mac;
      mac_t       src_mac;
      ethertype_t ethertype;
      port_t      src_port;
   } eth_hdr_t;

endpackage

/* rtl/eth_parser.sv */
module eth_parser
   import eth_pkg::*, pkt_bus_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  pkt_word_t in_word,
   input  logic      in_wr,
   output eth_hdr_t  hdr,
   output logic      eth_done
);

   typedef enum logic [2:0] {
      read_word_1,
      read_word_2,
      read_word_3,
      read_word_4,
      wait_eop
   } state_t;

   state_t   state;
   state_t   state_next;
   logic     eth_done_next;
   eth_hdr_t hdr_next;
   logic     is_payload;
   logic     is_mod_hdr;
   logic     is_eop;

   assign is_payload = in_wr && (in_word.ctrl == ctrl_payload);
   assign is_mod_hdr = in_wr && (in_word.ctrl == ctrl_module_hdr);
   assign is_eop     = in_wr && (in_word.ctrl != ctrl_payload)
                             && (in_word.ctrl != ctrl_module_hdr);

   // ------------------------------------------------------------
   // next state and field extraction
   // ------------------------------------------------------------
   always_comb begin
      state_next    = state;
      eth_done_next = eth_done;
      hdr_next      = hdr;
      case (state)
         read_word_1: begin
            if (is_mod_hdr) begin
               hdr_next.src_port = in_word.data[2:0];
            end else if (is_payload) begin
               hdr_next.dst_mac[47:16] = in_word.data;
               state_next = read_word_2;
            end
         end
         read_word_2: begin
            if (in_wr) begin
               hdr_next.dst_mac[15:0]  = in_word.data[31:16];
               hdr_next.src_mac[47:32] = in_word.data[15:0];
               state_next = read_word_3;
            end
         end
         read_word_3: begin
            if (in_wr) begin
               hdr_next.src_mac[31:0] = in_word.data;
               state_next = read_word_4;
            end
         end
         read_word_4: begin
            if (in_wr) begin
               hdr_next.ethertype = in_word.data[31:16];
               eth_done_next = 1'b1;                // header complete.
               state_next = wait_eop;
            end
         end
         wait_eop: begin
            if (is_eop) begin
               eth_done_next = 1'b0;
               state_next = read_word_1;
            end
         end
         default: begin
            state_next = read_word_1;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= read_word_1;
         eth_done <= 1'b0;
      end else begin
         state    <= state_next;
         eth_done <= eth_done_next;
      end
   end

   always_ff @(posedge clk) begin
      hdr <= hdr_next;
   end

endmodule

/* rtl/port_lookup.sv */
module port_lookup
   import eth_pkg::*, pkt_bus_pkg::*;
#(
   parameter int num_entries = 4
) (
   input  logic          clk,
   input  logic          reset,
   input  eth_hdr_t      hdr,
   input  logic          eth_done,
   input  table_entry_t  entries [num_entries],
   output fwd_decision_t decision,
   output logic          decision_valid,
   output logic          hit_pulse,
   output logic          miss_pulse
);

   logic       eth_done_q;
   logic       done_rise;
   logic       is_bcast;
   logic       hit;
   port_t      hit_port;
   port_mask_t flood_mask;
   port_mask_t mask_next;

   always_ff @(posedge clk) begin
      if (reset) begin
         eth_done_q <= 1'b0;
      end else begin
         eth_done_q <= eth_done;
      end
   end

   assign done_rise = eth_done && !eth_done_q;   // one lookup per packet.
   assign is_bcast  = (hdr.dst_mac == broadcast_mac);

   // ------------------------------------------------------------
   // table search
   // ------------------------------------------------------------
   // walk downward so the lowest matching index is the one kept.
   always_comb begin
      hit      = 1'b0;
      hit_port = '0;
      for (int i = num_entries - 1; i >= 0; i--) begin
         if (entries[i].valid && (entries[i].mac == hdr.dst_mac)) begin
            hit      = 1'b1;
            hit_port = entries[i].port;
         end
      end
   end

   assign flood_mask = ~(port_mask_t'(1'b1) << hdr.src_port);

   always_comb begin
      if (is_bcast) begin
         mask_next = flood_mask;
      end else if (hit) begin
         if (hit_port == hdr.src_port) begin
            mask_next = '0;                        // filtered.
         end else begin
            mask_next = port_mask_t'(1'b1) << hit_port;
         end
      end else begin
         mask_next = flood_mask;                   // unknown unicast.
      end
   end

   // ------------------------------------------------------------
   // decision register
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (done_rise) begin
         decision.dst_ports <= mask_next;
         decision.src_port  <= hdr.src_port;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         decision_valid <= 1'b0;
         hit_pulse      <= 1'b0;
         miss_pulse     <= 1'b0;
      end else begin
         decision_valid <= done_rise;
         hit_pulse      <= done_rise && !is_bcast && hit;
         miss_pulse     <= done_rise && !is_bcast && !hit;
      end
   end

endmodule

/* rtl/lookup_regs.sv */
module lookup_regs
   import pkt_bus_pkg::*;
#(
   parameter int num_entries = 4
) (
   input  logic         clk,
   input  logic         reset,
   input  logic         reg_wr,
   input  logic         reg_rd,
   input  reg_addr_t    reg_addr,
   input  reg_data_t    reg_wdata,
   output reg_data_t    reg_rdata,
   input  logic         hit_pulse,
   input  logic         miss_pulse,
   output table_entry_t entries [num_entries]
);

   localparam reg_addr_t hit_count_addr  = 8'h80;
   localparam reg_addr_t miss_count_addr = 8'h81;

   reg_data_t hit_count;
   reg_data_t miss_count;
   reg_data_t rd_mux;

   // ------------------------------------------------------------
   // table writes
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_entries; i++) begin
            entries[i] <= '0;
         end
      end else if (reg_wr) begin
         for (int i = 0; i < num_entries; i++) begin
            if (reg_addr == reg_addr_t'(2 * i)) begin
               entries[i].mac[31:0] <= reg_wdata;
            end
            if (reg_addr == reg_addr_t'(2 * i + 1)) begin
               entries[i].mac[47:32] <= reg_wdata[15:0];
               entries[i].port       <= reg_wdata[18:16];
               entries[i].valid      <= reg_wdata[31];
            end
         end
      end
   end

   // counters saturate at all ones and clear on a write.
   always_ff @(posedge clk) begin
      if (reset) begin
         hit_count  <= '0;
         miss_count <= '0;
      end else begin
         if (reg_wr && (reg_addr == hit_count_addr)) begin
            hit_count <= '0;
         end else if (hit_pulse && (hit_count != '1)) begin
            hit_count <= hit_count + 1'b1;
         end
         if (reg_wr && (reg_addr == miss_count_addr)) begin
            miss_count <= '0;
         end else if (miss_pulse && (miss_count != '1)) begin
            miss_count <= miss_count + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------
   // read path
   // ------------------------------------------------------------
   always_comb begin
      rd_mux = '0;                                 // unmapped reads zero.
      if (reg_addr == hit_count_addr) begin
         rd_mux = hit_count;
      end else if (reg_addr == miss_count_addr) begin
         rd_mux = miss_count;
      end
      for (int i = 0; i < num_entries; i++) begin
         if (reg_addr == reg_addr_t'(2 * i)) begin
            rd_mux = entries[i].mac[31:0];
         end
         if (reg_addr == reg_addr_t'(2 * i + 1)) begin
            rd_mux = {entries[i].valid, 12'd0, entries[i].port, entries[i].mac[47:32]};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reg_rd) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

/* rtl/eth_switch_lookup.sv */
module eth_switch_lookup
   import eth_pkg::*, pkt_bus_pkg::*;
#(
   parameter int num_entries = 4
) (
   input  logic          clk,
   input  logic          reset,
   input  pkt_word_t     in_word,
   input  logic          in_wr,
   output fwd_decision_t decision,
   output logic          decision_valid,
   input  logic          reg_wr,
   input  logic          reg_rd,
   input  reg_addr_t     reg_addr,
   input  reg_data_t     reg_wdata,
   output reg_data_t     reg_rdata
);

   eth_hdr_t     hdr;
   logic         eth_done;
   logic         hit_pulse;
   logic         miss_pulse;
   table_entry_t entries [num_entries];

   eth_parser eth_parser_inst (
      .clk      (clk),
      .reset    (reset),
      .in_word  (in_word),
      .in_wr    (in_wr),
      .hdr      (hdr),
      .eth_done (eth_done)
   );

   port_lookup #(
      .num_entries (num_entries)
   ) port_lookup_inst (
      .clk            (clk),
      .reset          (reset),
      .hdr            (hdr),
      .eth_done       (eth_done),
      .entries        (entries),
      .decision       (decision),
      .decision_valid (decision_valid),
      .hit_pulse      (hit_pulse),
      .miss_pulse     (miss_pulse)
   );

   lookup_regs #(
      .num_entries (num_entries)
   ) lookup_regs_inst (
      .clk        (clk),
      .reset      (reset),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .hit_pulse  (hit_pulse),
      .miss_pulse (miss_pulse),
      .entries    (entries)
   );

endmodule

/* verif/eth_switch_lookup_tb.sv */
module eth_switch_lookup_tb
   import eth_pkg::*, pkt_bus_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_entries    = 4;
   localparam int timeout_cycles = 300;
   localparam mac_t bcast        = 48'hffff_ffff_ffff;

   logic          clk;
   logic          reset;
   pkt_word_t     in_word;
   logic          in_wr;
   fwd_decision_t decision;
   logic          decision_valid;
   logic          reg_wr;
   logic          reg_rd;
   reg_addr_t     reg_addr;
   reg_data_t     reg_wdata;
   reg_data_t     reg_rdata;

   // reference copy of the MAC table and the counters.
   logic          mdl_valid [num_entries];
   port_t         mdl_port [num_entries];
   mac_t          mdl_mac [num_entries];
   reg_data_t     mdl_hits;
   reg_data_t     mdl_misses;

   fwd_decision_t rx_q [$];
   logic [31:0]   lcg_state;
   int            errors;
   int            checks;
   int            tests;
   int            test_errors;
   string         test_name;

   eth_switch_lookup #(
      .num_entries (num_entries)
   ) eth_switch_lookup_inst (
      .clk            (clk),
      .reset          (reset),
      .in_word        (in_word),
      .in_wr          (in_wr),
      .decision       (decision),
      .decision_valid (decision_valid),
      .reg_wr         (reg_wr),
      .reg_rd         (reg_rd),
      .reg_addr       (reg_addr),
      .reg_wdata      (reg_wdata),
      .reg_rdata      (reg_rdata)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(negedge clk) begin
      if (!reset && decision_valid) begin
         rx_q.push_back(decision);                 // sampled mid-cycle.
      end
   end

   // ------------------------------------------------------------
   // reference model and random numbers
   // ------------------------------------------------------------
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic mac_t rand_mac();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_rand();
      lo = next_rand();
      return {hi[15:0], lo};
   endfunction

   function automatic int match_index(mac_t dst);
      for (int i = 0; i < num_entries; i++) begin
         if (mdl_valid[i] && (mdl_mac[i] == dst)) begin
            return i;                              // lowest index wins.
         end
      end
      return -1;
   endfunction

   function automatic port_mask_t expected_mask(mac_t dst, port_t src);
      port_mask_t flood;
      int         idx;
      flood = ~(8'h01 << src);
      idx   = match_index(dst);
      if (dst == bcast || idx < 0) begin
         return flood;
      end
      return (mdl_port[idx] == src) ? 8'h00 : (8'h01 << mdl_port[idx]);
   endfunction

   task automatic tally(mac_t dst);
      if (dst != bcast) begin
         if (match_index(dst) >= 0) begin
            mdl_hits++;
         end else begin
            mdl_misses++;
         end
      end
   endtask

   // ------------------------------------------------------------
   // checks and bus tasks
   // ------------------------------------------------------------
   task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      end
   endtask

   task automatic reg_write(reg_addr_t addr, reg_data_t data);
      @(posedge clk);
      reg_wr    <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      @(posedge clk);
      reg_wr    <= 1'b0;
   endtask

   task automatic reg_read(reg_addr_t addr, output reg_data_t data);
      @(posedge clk);
      reg_rd   <= 1'b1;
      reg_addr <= addr;
      @(posedge clk);
      reg_rd   <= 1'b0;
      @(negedge clk);
      data = reg_rdata;
   endtask

   task automatic check_reg(reg_addr_t addr, reg_data_t exp, string what);
      reg_data_t val;
      reg_read(addr, val);
      check_value(what, exp, val);
   endtask

   task automatic check_counters();
      check_reg(8'h80, mdl_hits, "hit count");
      check_reg(8'h81, mdl_misses, "miss count");
   endtask

   task automatic write_entry(int idx, mac_t mac, port_t port, logic valid);
      reg_write(reg_addr_t'(2 * idx), mac[31:0]);
      reg_write(reg_addr_t'(2 * idx + 1), {valid, 12'd0, port, mac[47:32]});
      mdl_mac[idx]   = mac;
      mdl_port[idx]  = port;
      mdl_valid[idx] = valid;
   endtask

   // module header, four header payload words, end of packet.
   task automatic send_packet(port_t src, mac_t dst, mac_t src_mac, logic [15:0] etype);
      pkt_word_t words [6];
      words[0] = {29'd0, src, 4'h2};
      words[1] = {dst[47:16], 4'h0};
      words[2] = {dst[15:0], src_mac[47:32], 4'h0};
      words[3] = {src_mac[31:0], 4'h0};
      words[4] = {etype, 16'h0000, 4'h0};
      words[5] = {32'h0, 4'h1};
      for (int i = 0; i < 6; i++) begin
         @(posedge clk);
         in_wr   <= 1'b1;
         in_word <= words[i];
      end
   endtask

   task automatic idle_bus();
      @(posedge clk);
      in_wr <= 1'b0;
   endtask

   task automatic wait_for_decisions(int count, output logic arrived);
      int n;
      n = 0;
      while (rx_q.size() < count && n < timeout_cycles) begin
         @(posedge clk);
         n++;
      end
      arrived = (rx_q.size() >= count);
      if (!arrived) begin
         errors++;
         $display("ERROR: decision did not arrive before the timeout in test %s", test_name);
      end
   endtask

   task automatic compare_decision(port_mask_t exp_mask, port_t src, fwd_decision_t got);
      check_value("dst_ports", exp_mask, got.dst_ports);
      check_value("src_port", src, got.src_port);
   endtask

   task automatic run_packet(port_t src, mac_t dst);
      fwd_decision_t got;
      logic          arrived;
      send_packet(src, dst, rand_mac(), 16'h0800);
      idle_bus();
      wait_for_decisions(1, arrived);
      if (arrived) begin
         got = rx_q.pop_front();
         compare_decision(expected_mask(dst, src), src, got);
      end
      tally(dst);
   endtask

   task automatic start_test(string name);
      test_name   = name;
      test_errors = errors;
      tests++;
   endtask

   task automatic end_test();
      $display("test %s: %0d error(s)", test_name, errors - test_errors);
   endtask

   // ------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------
   task automatic reset_and_readback();
      mac_t mac;
      start_test("reset_readback");
      for (int a = 0; a < 2 * num_entries; a++) begin
         check_reg(reg_addr_t'(a), 32'h0, "table word after reset");
      end
      check_counters();
      for (int i = 0; i < num_entries; i++) begin
         mac = rand_mac();
         write_entry(i, mac, port_t'(i + 1), 1'b1);
         check_reg(reg_addr_t'(2 * i), mac[31:0], "mac low word");
         check_reg(reg_addr_t'(2 * i + 1), {1'b1, 12'd0, port_t'(i + 1), mac[47:32]},
                   "mac high word");
      end
      check_reg(8'h08, 32'h0, "unmapped 0x08");
      check_reg(8'h40, 32'h0, "unmapped 0x40");
      check_reg(8'h82, 32'h0, "unmapped 0x82");
      check_reg(8'hff, 32'h0, "unmapped 0xff");
      end_test();
   endtask

   task automatic broadcast_flood();
      start_test("broadcast");
      run_packet(3'd3, bcast);
      check_counters();
      end_test();
   endtask

   task automatic table_hit();
      start_test("table_hit");
      write_entry(1, 48'h02_00_5e_10_20_30, 3'd5, 1'b1);
      run_packet(3'd0, 48'h02_00_5e_10_20_30);
      check_counters();
      end_test();
   endtask

   task automatic miss_and_flood();
      mac_t mac;
      start_test("miss_flood");
      run_packet(3'd6, rand_mac());
      mac = rand_mac();
      write_entry(2, mac, 3'd3, 1'b0);              // present but invalid.
      run_packet(3'd1, mac);
      check_counters();
      end_test();
   endtask

   task automatic filter_and_priority();
      mac_t mac;
      start_test("filter_priority");
      run_packet(3'd5, 48'h02_00_5e_10_20_30);
      mac = rand_mac();
      write_entry(0, mac, 3'd2, 1'b1);
      write_entry(3, mac, 3'd7, 1'b1);
      run_packet(3'd4, mac);
      check_counters();
      end_test();
   endtask

   task automatic back_to_back();
      mac_t          dsts [10];
      port_t         srcs [10];
      port_mask_t    exps [10];
      fwd_decision_t got;
      logic [31:0]   r;
      logic          arrived;
      start_test("back_to_back");
      reg_write(8'h80, 32'h0);
      reg_write(8'h81, 32'h0);
      mdl_hits   = '0;
      mdl_misses = '0;
      for (int i = 0; i < 10; i++) begin
         r       = next_rand();
         srcs[i] = r[2:0];
         case (r[5:4])
            2'd0:    dsts[i] = bcast;
            2'd3:    dsts[i] = rand_mac();
            default: dsts[i] = mdl_mac[r[9:8] % num_entries];
         endcase
         exps[i] = expected_mask(dsts[i], srcs[i]);
         tally(dsts[i]);
      end
      for (int i = 0; i < 10; i++) begin
         send_packet(srcs[i], dsts[i], rand_mac(), 16'h86dd);
      end
      idle_bus();
      wait_for_decisions(10, arrived);
      repeat (20) @(posedge clk);
      check_value("decision count", 10, rx_q.size());
      if (arrived) begin
         for (int i = 0; i < 10; i++) begin
            got = rx_q.pop_front();
            compare_decision(exps[i], srcs[i], got);
         end
      end
      check_counters();
      end_test();
   endtask

   initial begin
      lcg_state  = 32'd85441;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      mdl_hits   = '0;
      mdl_misses = '0;
      reset      = 1'b1;
      in_word    = '0;
      in_wr      = 1'b0;
      reg_wr     = 1'b0;
      reg_rd     = 1'b0;
      reg_addr   = '0;
      reg_wdata  = '0;
      for (int i = 0; i < num_entries; i++) begin
         mdl_valid[i] = 1'b0;
         mdl_port[i]  = '0;
         mdl_mac[i]   = '0;
      end
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      reset_and_readback();
      broadcast_flood();
      table_hit();
      miss_and_flood();
      filter_and_priority();
      back_to_back();

      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* eth_switch_lookup.f */
rtl/pkt_bus_pkg.sv
rtl/eth_pkg.sv
rtl/eth_parser.sv
rtl/port_lookup.sv
rtl/lookup_regs.sv
rtl/eth_switch_lookup.sv
verif/eth_switch_lookup_tb.sv

/* Bender.yml */
package:
  name: eth_switch_lookup

sources:
  # packages first, eth_pkg imports pkt_bus_pkg
  - rtl/pkt_bus_pkg.sv
  - rtl/eth_pkg.sv
  - rtl/eth_parser.sv
  - rtl/port_lookup.sv
  - rtl/lookup_regs.sv
  - rtl/eth_switch_lookup.sv
  - target: test
    files:
      - verif/eth_switch_lookup_tb.sv
